/* rtl/bramFifo_params.svh */
// Block RAM FIFO exerciser parameters
// Word width, RAM depth, almost-full margin and reader pacing
`ifndef BRAM_FIFO_PARAMS_SVH
`define BRAM_FIFO_PARAMS_SVH

//------------------------------
// FIFO geometry
//------------------------------
// Data word width
`define BF_DATA_WIDTH     8
// RAM words
`define BF_DEPTH          1024
// Pointer width, log2 of depth
`define BF_ADDR_WIDTH     10
// Free words left when full rises
`define BF_ALMOST_MARGIN  16

//------------------------------
// Reader pacing
//------------------------------
// Cycles between reads, 100 ms at 100 MHz
`define BF_READ_INTERVAL  10000000

`endif

/* rtl/fifoTypesPkg.sv */
// FIFO transfer types
// Write and read structs plus pointer and occupancy types
`default_nettype none

`include "bramFifo_params.svh"

package fifoTypesPkg;

	// Write side, valid/ready handshake
	typedef struct packed {
		logic [`BF_DATA_WIDTH-1:0] data;
		logic                      valid;
	} fifoWrite_t;

	// Read response, valid one cycle after request
	typedef struct packed {
		logic [`BF_DATA_WIDTH-1:0] data;
		logic                      valid;
	} fifoRead_t;

	// RAM address, wraps at depth
	typedef logic [`BF_ADDR_WIDTH-1:0] fifoPtr_t;
	// One bit wider so a full RAM is countable
	typedef logic [`BF_ADDR_WIDTH:0] fifoCount_t;

endpackage

`default_nettype wire

/* rtl/paceTypesPkg.sv */
// Paced reader types
// Reader FSM states and the LED status bundle
`default_nettype none

package paceTypesPkg;

	// Reader FSM
	typedef enum logic [1:0] {
		WAIT_TICK = 2'd0,
		REQUEST   = 2'd1,
		CAPTURE   = 2'd2
	} readerState_t;

	// Board status outputs
	typedef struct packed {
		// Low six bits of last word
		logic [5:0] led;
		// Sticky sequence error
		logic       seqErr;
	} ledStatus_t;

endpackage

`default_nettype wire

/* rtl/resetConditioner.sv */
// Reset conditioner
// Push switch and PLL lock merged into one active-high reset
// Asserts asynchronously, releases two edges after lock
`timescale 1ns/100ps
`default_nettype none

module resetConditioner
(
	input  logic iSCLK,
	input  logic iPushSw,
	input  logic iPllLocked,
	output logic rst
);

	// Two-stage synchroniser, bit 1 is the reset
	logic [1:0] rstSync;

	//------------------------------
	// Synchroniser
	//------------------------------
	// Switch low sets both stages at once
	// Lock low shifts in a one, reaching rst in two edges
	// Lock high shifts in zeros, release on the second edge
	always_ff @(posedge iSCLK or negedge iPushSw)
	begin
		if (!iPushSw)
		begin
			rstSync <= 2'b11;
		end
		else
		begin
			rstSync <= {rstSync[0], ~iPllLocked};
		end
	end

	// Single reset tree for the whole clock domain
	assign rst = rstSync[1];

endmodule

`default_nettype wire

/* rtl/ramFifoController.sv */
// Block RAM FIFO controller
// Inferred dual-port RAM with registered read port
// Registered almost-full and empty flags derived from occupancy
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module ramFifoController
	import fifoTypesPkg::*;
(
	input  logic       iSCLK,
	input  logic       rst,
	input  fifoWrite_t wr,
	output logic       wrReady,
	input  logic       rdReq,
	output fifoRead_t  rd,
	output logic       rdEmpty,
	output logic       full
);

	// Count at which full rises, 1008
	localparam fifoCount_t lpFullLevel = fifoCount_t'(`BF_DEPTH - `BF_ALMOST_MARGIN);

	// Storage, inferred as block RAM
	logic [`BF_DATA_WIDTH-1:0] mem [0:`BF_DEPTH-1];

	fifoPtr_t                  wrPtr;
	fifoPtr_t                  rdPtr;
	fifoCount_t                count;
	fifoCount_t                countNext;
	logic                      wrEn;
	logic                      rdEn;
	logic [`BF_DATA_WIDTH-1:0] rdData;
	logic                      rdValid;

	//------------------------------
	// Handshake
	//------------------------------
	// Ready is just the inverse of almost-full
	assign wrReady = ~full;
	assign wrEn    = wr.valid & ~full;
	// Request is trusted, empty is checked by the reader
	assign rdEn    = rdReq;

	//------------------------------
	// Occupancy
	//------------------------------
	always_comb
	begin
		case ({wrEn, rdEn})
			2'b10:   countNext = count + fifoCount_t'(1);
			2'b01:   countNext = count - fifoCount_t'(1);
			// Idle or simultaneous read and write
			default: countNext = count;
		endcase
	end

	// Pointers, count and flags
	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			full    <= 1'b0;
			rdEmpty <= 1'b1;
			rdValid <= 1'b0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			count   <= countNext;
			// Flags track the count on the same edge
			full    <= (countNext >= lpFullLevel);
			rdEmpty <= (countNext == '0);
			// Response strobe one cycle behind request
			rdValid <= rdEn;
		end
	end

	//------------------------------
	// RAM ports
	//------------------------------
	// Write port
	always_ff @(posedge iSCLK)
	begin
		if (wrEn)
			mem[wrPtr] <= wr.data;
	end

	// Registered read port, head word
	always_ff @(posedge iSCLK)
	begin
		if (rdEn)
			rdData <= mem[rdPtr];
	end

	assign rd.data  = rdData;
	assign rd.valid = rdValid;

endmodule

`default_nettype wire

/* rtl/patternWriter.sv */
// Pattern writer
// Pushes an incrementing 8-bit count at full rate under valid/ready
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module patternWriter
	import fifoTypesPkg::*;
(
	input  logic       iSCLK,
	input  logic       rst,
	output fifoWrite_t wr,
	input  logic       wrReady
);

	// Current word on offer
	logic [`BF_DATA_WIDTH-1:0] pattern;
	// Valid flop, low in reset then held high
	logic                      validReg;

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			pattern  <= '0;
			validReg <= 1'b0;
		end
		else
		begin
			validReg <= 1'b1;
			// Advance only on an accepted word, wraps at 255
			if (validReg && wrReady)
				pattern <= pattern + 1'b1;
		end
	end

	assign wr.data  = pattern;
	assign wr.valid = validReg;

endmodule

`default_nettype wire

/* rtl/pacedReader.sv */
// Paced reader
// Pops one FIFO word per interval, shows it on the LEDs
// and flags any break in the incrementing sequence
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module pacedReader
	import fifoTypesPkg::*, paceTypesPkg::*;
#(
	parameter int pReadInterval = `BF_READ_INTERVAL
)
(
	input  logic       iSCLK,
	input  logic       rst,
	input  logic       rdEmpty,
	output logic       rdReq,
	input  fifoRead_t  rd,
	output ledStatus_t status
);

	// Timer width, at least one bit
	localparam int lpTickWidth = (pReadInterval > 1) ? $clog2(pReadInterval) : 1;

	logic [lpTickWidth-1:0]    tickCnt;
	logic                      tick;
	readerState_t              state;
	readerState_t              stateNext;
	logic [`BF_DATA_WIDTH-1:0] prevWord;
	logic [`BF_DATA_WIDTH-1:0] expectWord;
	logic                      havePrev;

	//------------------------------
	// Interval timer
	//------------------------------
	assign tick = (tickCnt == lpTickWidth'(pReadInterval - 1));

	always_ff @(posedge iSCLK)
	begin
		if (rst || tick)
			tickCnt <= '0;
		else
			tickCnt <= tickCnt + 1'b1;
	end

	//------------------------------
	// Read FSM
	//------------------------------
	always_comb
	begin
		stateNext = state;
		case (state)
			// Tick on empty FIFO is skipped
			WAIT_TICK: if (tick && !rdEmpty) stateNext = REQUEST;
			REQUEST:   stateNext = CAPTURE;
			CAPTURE:   if (rd.valid) stateNext = WAIT_TICK;
			default:   stateNext = WAIT_TICK;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (rst)
			state <= WAIT_TICK;
		else
			state <= stateNext;
	end

	// One-cycle request pulse
	assign rdReq = (state == REQUEST);

	//------------------------------
	// LED latch and checker
	//------------------------------
	// Previous word plus one, wraps mod 256
	assign expectWord = prevWord + 1'b1;

	always_ff @(posedge iSCLK)
	begin
		if (rst)
		begin
			status.led    <= '0;
			status.seqErr <= 1'b0;
			havePrev      <= 1'b0;
		end
		else if (rd.valid)
		begin
			status.led <= rd.data[5:0];
			havePrev   <= 1'b1;
			// First word after reset has nothing to compare against
			if (havePrev && (rd.data != expectWord))
				status.seqErr <= 1'b1;
		end
	end

	// Last captured word
	always_ff @(posedge iSCLK)
	begin
		if (rd.valid)
			prevWord <= rd.data;
	end

endmodule

`default_nettype wire

/* rtl/bramFifoTop.sv */
// Block RAM FIFO exerciser, board top
// Reset conditioner, pattern writer, FIFO and paced reader
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module bramFifoTop
	import fifoTypesPkg::*, paceTypesPkg::*;
#(
	parameter int pReadInterval = `BF_READ_INTERVAL
)
(
	input  logic       iSCLK,
	input  logic       iPushSw,
	input  logic       iPllLocked,
	output logic [5:0] oLed,
	output logic       oSeqErr,
	output logic       oFifoFull
);

	logic       rst;
	fifoWrite_t wr;
	logic       wrReady;
	logic       rdReq;
	fifoRead_t  rd;
	logic       rdEmpty;
	logic       full;
	ledStatus_t status;

	//------------------------------
	// Reset
	//------------------------------
	resetConditioner uReset (.iSCLK(iSCLK), .iPushSw(iPushSw), .iPllLocked(iPllLocked), .rst(rst));

	//------------------------------
	// Data path
	//------------------------------
	// Source runs at full rate
	patternWriter uWriter (.iSCLK(iSCLK), .rst(rst), .wr(wr), .wrReady(wrReady));

	ramFifoController uFifo (
		.iSCLK(iSCLK), .rst(rst), .wr(wr), .wrReady(wrReady),
		.rdReq(rdReq), .rd(rd), .rdEmpty(rdEmpty), .full(full)
	);

	// Consumer drains one word per interval
	pacedReader #(.pReadInterval(pReadInterval)) uReader (
		.iSCLK(iSCLK), .rst(rst), .rdEmpty(rdEmpty),
		.rdReq(rdReq), .rd(rd), .status(status)
	);

	// Board outputs
	assign oLed      = status.led;
	assign oSeqErr   = status.seqErr;
	assign oFifoFull = full;

endmodule

`default_nettype wire

/* testbench/bramFifo_chk.sv */
// FIFO and reader protocol assertions
// Bound into the FIFO controller and the paced reader
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module bramFifoChk
#(
	// Selects the reader-side set, FIFO-side set otherwise
	parameter bit pReaderSide = 1'b0
)
(
	input wire logic                    iSCLK,
	input wire logic                    rst,
	input wire logic [`BF_ADDR_WIDTH:0] count,
	input wire logic                    rdReq,
	input wire logic                    rdEmpty,
	input wire logic                    rdValid,
	input wire logic                    seqErr
);

	localparam int lpFullLevel = `BF_DEPTH - `BF_ALMOST_MARGIN;

	generate
		if (pReaderSide)
		begin : gReader
			//------------------------------
			// Reader side
			//------------------------------
			noReadWhenEmpty: assert property (@(posedge iSCLK) disable iff (rst)
				rdReq |-> !rdEmpty)
				else $error("read request while FIFO empty");

			// Response strobe exactly one cycle behind request
			validAfterReq: assert property (@(posedge iSCLK) disable iff (rst)
				rdReq |=> rdValid)
				else $error("read valid missing after request");

			validOnlyAfterReq: assert property (@(posedge iSCLK) disable iff (rst)
				rdValid |-> $past(rdReq))
				else $error("read valid without request");

			// Sticky until reset
			seqErrSticky: assert property (@(posedge iSCLK) disable iff (rst)
				!$fell(seqErr))
				else $error("sequence error flag cleared outside reset");
		end
		else
		begin : gFifo
			//------------------------------
			// FIFO side
			//------------------------------
			// Writes stop at the almost-full level
			countBound: assert property (@(posedge iSCLK) disable iff (rst)
				count <= lpFullLevel)
				else $error("FIFO count above almost-full level");
		end
	endgenerate

endmodule

bind ramFifoController bramFifoChk #(.pReaderSide(1'b0)) uFifoChk (
	.iSCLK(iSCLK), .rst(rst), .count(count), .rdReq(rdReq),
	.rdEmpty(rdEmpty), .rdValid(rd.valid), .seqErr(1'b0)
);

bind pacedReader bramFifoChk #(.pReaderSide(1'b1)) uReaderChk (
	.iSCLK(iSCLK), .rst(rst), .count('0), .rdReq(rdReq),
	.rdEmpty(rdEmpty), .rdValid(rd.valid), .seqErr(status.seqErr)
);

`default_nettype wire

/* testbench/tbBramFifo.sv */
// Block RAM FIFO exerciser testbench
// Directed tests for reset, lock hold-off, fill, LED sequence and relock
`timescale 1ns/100ps
`default_nettype none

`include "bramFifo_params.svh"

module tbBramFifo;

	// Short read interval so the FIFO fills quickly
	localparam int lpInterval = 8;
	localparam int lpFullLevel = `BF_DEPTH - `BF_ALMOST_MARGIN;
	// Net fill rate is 7/8 word per cycle, plus slack
	localparam int lpFillLimit = lpFullLevel * lpInterval / (lpInterval - 1) + 100;
	localparam int lpChangeLimit = 4 * lpInterval;
	localparam int lpTimeoutCycles = 20000;

	logic       iSCLK;
	logic       iPushSw;
	logic       iPllLocked;
	logic [5:0] oLed;
	logic       oSeqErr;
	logic       oFifoFull;

	int valueErrors = 0;
	int stallErrors = 0;
	int cycleCount = 0;

	bramFifoTop #(.pReadInterval(lpInterval)) dut (
		.iSCLK(iSCLK), .iPushSw(iPushSw), .iPllLocked(iPllLocked),
		.oLed(oLed), .oSeqErr(oSeqErr), .oFifoFull(oFifoFull)
	);

	// 20 ns clock
	initial
	begin
		iSCLK = 1'b0;
		forever #10 iSCLK = ~iSCLK;
	end

	//------------------------------
	// Run limit
	//------------------------------
	always @(posedge iSCLK)
	begin
		cycleCount++;
		if (cycleCount >= lpTimeoutCycles)
		begin
			$display("Timeout: run did not finish within %0d cycles", lpTimeoutCycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Drive and sample point, 2 ns after the edge
	task automatic stepCycle;
		@(posedge iSCLK);
		#2;
	endtask

	task automatic reportMismatch(input string msg);
		valueErrors++;
		$display("FAIL at %0t ns: %s", $time, msg);
	endtask

	task automatic reportStall(input string msg);
		stallErrors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	//------------------------------
	// Tests
	//------------------------------
	// Switch held low for 4 cycles
	task automatic checkResetState;
		iPushSw = 1'b0;
		repeat (4) stepCycle;
		if (oLed != 6'd0 || oSeqErr || oFifoFull)
			reportMismatch($sformatf("outputs not clear in reset, led %0d", oLed));
	endtask

	// Writer stays in reset until lock
	task automatic holdWithoutLock;
		int i;
		iPushSw = 1'b1;
		for (i = 0; i < 200; i++)
		begin
			stepCycle;
			if (oLed != 6'd0 || oFifoFull)
				reportMismatch($sformatf("activity without lock, led %0d", oLed));
		end
	endtask

	task automatic fillToAlmostFull;
		int waitCycles;
		int lowRun;
		int i;
		iPllLocked = 1'b1;
		waitCycles = 0;
		while (!oFifoFull && waitCycles < lpFillLimit)
		begin
			stepCycle;
			waitCycles++;
		end
		if (!oFifoFull)
		begin
			reportStall("full flag never rose after lock");
			return;
		end
		// Each read frees one word, refilled right away
		lowRun = 0;
		for (i = 0; i < 200; i++)
		begin
			stepCycle;
			if (oFifoFull)
				lowRun = 0;
			else
				lowRun++;
			if (lowRun == 4)
				reportMismatch("full flag low for more than 3 cycles");
		end
	endtask

	// Each new LED value is the last plus one mod 64
	task automatic followLedSequence(input int changes);
		logic [5:0] lastLed;
		int waitCycles;
		int i;
		lastLed = oLed;
		for (i = 0; i < changes; i++)
		begin
			waitCycles = 0;
			while (oLed == lastLed && waitCycles < lpChangeLimit)
			begin
				stepCycle;
				waitCycles++;
			end
			if (oLed == lastLed)
			begin
				reportStall($sformatf("LED stuck at %0d", lastLed));
				return;
			end
			if (oLed != 6'(lastLed + 6'd1))
				reportMismatch($sformatf("LED %0d after %0d", oLed, lastLed));
			if (oSeqErr)
				reportMismatch("sequence error flag set");
			lastLed = oLed;
		end
	endtask

	task automatic loseAndRegainLock;
		int relockDelay;
		int waitCycles;
		iPllLocked = 1'b0;
		// Two synchroniser stages plus the output registers
		repeat (3) stepCycle;
		if (oLed != 6'd0 || oFifoFull)
			reportMismatch($sformatf("no reset on lock loss, led %0d", oLed));
		relockDelay = 5 + ($urandom % 36);
		repeat (relockDelay) stepCycle;
		iPllLocked = 1'b1;
		// First word is 0, so the first visible change is 1
		waitCycles = 0;
		while (oLed == 6'd0 && waitCycles < 100)
		begin
			stepCycle;
			waitCycles++;
		end
		if (oLed == 6'd0)
			reportStall("LED never changed after relock");
		else if (oLed != 6'd1)
			reportMismatch($sformatf("first LED after relock %0d", oLed));
		followLedSequence(20);
	endtask

	//------------------------------
	// Main sequence
	//------------------------------
	initial
	begin
		int unsigned seedSink;
		seedSink = $urandom(32'h3fdb_6a8a);
		iPushSw = 1'b0;
		iPllLocked = 1'b0;
		checkResetState;
		holdWithoutLock;
		fillToAlmostFull;
		followLedSequence(100);
		loseAndRegainLock;
		$display("Errors: %0d wrong values, %0d missed events", valueErrors, stallErrors);
		if (valueErrors == 0 && stallErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/fifoTypesPkg.sv
rtl/paceTypesPkg.sv
rtl/resetConditioner.sv
rtl/ramFifoController.sv
rtl/patternWriter.sv
rtl/pacedReader.sv
rtl/bramFifoTop.sv
testbench/bramFifo_chk.sv
testbench/tbBramFifo.sv

/* Bender.yml */
package:
  name: bram_fifo_exerciser

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fifoTypesPkg.sv
      - rtl/paceTypesPkg.sv
      - rtl/resetConditioner.sv
      - rtl/ramFifoController.sv
      - rtl/patternWriter.sv
      - rtl/pacedReader.sv
      - rtl/bramFifoTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/bramFifo_chk.sv
      - testbench/tbBramFifo.sv
